//--- tcu_defs.svh
// Macro defaults for the integer dot-product unit.
// The latencies count enabled clock edges only, and each must be at least 1.
`ifndef TCU_DEFS_SVH
`define TCU_DEFS_SVH

// word lanes per dot product
`define TCU_NUM_LANES 4

// multiply stage depth, shared by the lane sums and the scale bundle
`define TCU_MUL_LATENCY 2

// accumulate stage depth after the adder tree
`define TCU_ACC_LATENCY 2

// total input to d_val delay in enabled edges
`define TCU_TOTAL_LATENCY (`TCU_MUL_LATENCY + `TCU_ACC_LATENCY)

`endif

//--- tcu_pkg.sv
// Types and constants shared by the dot-product unit.
// Format codes not listed in fmt_t produce a zero product.
`default_nettype none

package tcu_pkg;

    // integer source formats, bit 3 marks the integer group
    typedef enum logic [3:0] {
        FMT_I8   = 4'h8,
        FMT_U8   = 4'h9,
        FMT_I4   = 4'ha,
        FMT_U4   = 4'hb,
        FMT_MXI8 = 4'hc
    } fmt_t;

    // subtracted from each e8m0 scale factor
    localparam logic signed [8:0] E8M0_BIAS = 9'sd133;

    // format, addend and combined shift, delayed next to the lane sums
    typedef struct packed {
        fmt_t              fmt;
        logic [31:0]       c_val;
        logic signed [8:0] shift;
    } scale_bundle_t;

endpackage

`default_nettype wire

//--- tcu_dp_if.sv
// Links the multiply and scale stages to the accumulator.
// All signals are already aligned to the same pipeline slot.
`timescale 1ns/1ps
`default_nettype none

interface tcu_dp_if #(
    parameter int N = 4
);
    import tcu_pkg::*;

    logic [N-1:0][31:0] lane_sum;
    fmt_t               fmt;
    logic [31:0]        c_val;
    logic signed [8:0]  shift;

    modport mul_src (
        output lane_sum
    );

    modport scale_src (
        output fmt,
        output c_val,
        output shift
    );

    modport acc_sink (
        input lane_sum,
        input fmt,
        input c_val,
        input shift
    );

endinterface

`default_nettype wire

//--- tcu_pipe_reg.sv
// Enable-gated delay line; every stage clears to zero on reset.
// DEPTH must be 1 or more. The line holds while enable is low.
`timescale 1ns/1ps
`default_nettype none

module tcu_pipe_reg #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  T     data_in,
    output T     data_out
);

    T stages [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else if (enable) begin
            stages[0] <= data_in;
            // shift toward the output
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- tcu_int_mul.sv
// Per-lane packed multiply and reduce, then TCU_MUL_LATENCY enabled stages.
// FMT_MXI8 multiplies as signed int8; the block scale is applied downstream.
// Unknown format codes give a zero lane sum. All sums wrap modulo 2^32.
`timescale 1ns/1ps
`default_nettype none
`include "tcu_defs.svh"

module tcu_int_mul #(
    parameter int N = `TCU_NUM_LANES
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  tcu_pkg::fmt_t      fmt_s,
    input  logic [N-1:0][31:0] a_row,
    input  logic [N-1:0][31:0] b_col,
    tcu_dp_if.mul_src          dp
);
    import tcu_pkg::*;

    // dot product of the packed elements of one word pair
    function automatic logic [31:0] lane_dot(
        input fmt_t        f,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] acc;
        logic [31:0] ea;
        logic [31:0] eb;
        logic        sgn;
        begin
            acc = '0;
            sgn = (f == FMT_I8) || (f == FMT_I4) || (f == FMT_MXI8);
            case (f)
                FMT_I8, FMT_U8, FMT_MXI8: begin
                    for (int j = 0; j < 4; j++) begin
                        ea  = {{24{sgn & a[8*j+7]}}, a[8*j +: 8]};
                        eb  = {{24{sgn & b[8*j+7]}}, b[8*j +: 8]};
                        // low 32 bits are exact for either signedness
                        acc = acc + ea * eb;
                    end
                end
                FMT_I4, FMT_U4: begin
                    for (int j = 0; j < 8; j++) begin
                        ea  = {{28{sgn & a[4*j+3]}}, a[4*j +: 4]};
                        eb  = {{28{sgn & b[4*j+3]}}, b[4*j +: 4]};
                        acc = acc + ea * eb;
                    end
                end
                default: begin
                    acc = '0;
                end
            endcase
            lane_dot = acc;
        end
    endfunction

    logic [N-1:0][31:0] lane_d;
    logic [N-1:0][31:0] lane_q;

    for (genvar i = 0; i < N; i++) begin : g_lane
        assign lane_d[i] = lane_dot(fmt_s, a_row[i], b_col[i]);

        tcu_pipe_reg #(
            .T     (logic [31:0]),
            .DEPTH (`TCU_MUL_LATENCY)
        ) u_lane_pipe (
            .clk      (clk),
            .reset    (reset),
            .enable   (enable),
            .data_in  (lane_d[i]),
            .data_out (lane_q[i])
        );
    end

    assign dp.lane_sum = lane_q;

endmodule

`default_nettype wire

//--- tcu_scale_unit.sv
// Builds the block-scale shift and delays it with format and addend.
// The shift is (sf_a - 133) + (sf_b - 133) for FMT_MXI8, zero otherwise.
// It wraps in 9 bits, but every wrapped value is 32 or more and scales to zero.
`timescale 1ns/1ps
`default_nettype none
`include "tcu_defs.svh"

module tcu_scale_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          enable,
    input  tcu_pkg::fmt_t fmt_s,
    input  logic [31:0]   c_val,
    input  logic [7:0]    sf_a,
    input  logic [7:0]    sf_b,
    tcu_dp_if.scale_src   dp
);
    import tcu_pkg::*;

    logic signed [8:0] exp_a;
    logic signed [8:0] exp_b;
    scale_bundle_t     bundle_d;
    scale_bundle_t     bundle_q;

    // unbiased e8m0 exponents
    assign exp_a = $signed({1'b0, sf_a}) - E8M0_BIAS;
    assign exp_b = $signed({1'b0, sf_b}) - E8M0_BIAS;

    always_comb begin
        bundle_d.fmt   = fmt_s;
        bundle_d.c_val = c_val;
        if (fmt_s == FMT_MXI8) begin
            bundle_d.shift = exp_a + exp_b;
        end else begin
            bundle_d.shift = 9'sd0;
        end
    end

    // same depth as the lane pipes, so both halves meet in one slot
    tcu_pipe_reg #(
        .T     (scale_bundle_t),
        .DEPTH (`TCU_MUL_LATENCY)
    ) u_scale_pipe (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (bundle_d),
        .data_out (bundle_q)
    );

    assign dp.fmt   = bundle_q.fmt;
    assign dp.c_val = bundle_q.c_val;
    assign dp.shift = bundle_q.shift;

endmodule

`default_nettype wire

//--- tcu_int_acc.sv
// Sums the lanes, applies the block-scale shift, adds the addend, then delays.
// Right shifts work on the magnitude, so negative totals truncate toward zero.
// A shift of 32 or more in either direction gives zero. Everything wraps.
`timescale 1ns/1ps
`default_nettype none
`include "tcu_defs.svh"

module tcu_int_acc #(
    parameter int N = `TCU_NUM_LANES
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    tcu_dp_if.acc_sink  dp,
    output logic [31:0] d_val
);

    logic [31:0] total;
    logic        total_neg;
    logic [31:0] total_abs;
    logic [8:0]  rsh;
    logic [31:0] mag_shr;
    logic [31:0] scaled;
    logic [31:0] acc_d;

    // adder tree over the lane sums
    always_comb begin
        total = '0;
        for (int i = 0; i < N; i++) begin
            total = total + dp.lane_sum[i];
        end
    end

    assign total_neg = total[31];
    assign total_abs = total_neg ? -total : total;

    // magnitude of a negative shift, 256 for the most negative code
    assign rsh     = -dp.shift;
    assign mag_shr = total_abs >> rsh[4:0];

    always_comb begin
        if (!dp.shift[8]) begin
            if (dp.shift[7:5] != 3'd0) begin
                scaled = '0;
            end else begin
                scaled = total << dp.shift[4:0];
            end
        end else if (rsh[8:5] != 4'd0) begin
            scaled = '0;
        end else begin
            scaled = total_neg ? -mag_shr : mag_shr;
        end
    end

    assign acc_d = scaled + dp.c_val;

    tcu_pipe_reg #(
        .T     (logic [31:0]),
        .DEPTH (`TCU_ACC_LATENCY)
    ) u_acc_pipe (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (acc_d),
        .data_out (d_val)
    );

endmodule

`default_nettype wire

//--- tcu_int_fedp.sv
// Integer fused dot-product unit with addend and optional block scale.
// d_val follows the inputs after exactly TCU_TOTAL_LATENCY enabled edges.
// Inputs are sampled only on edges where enable is high; reset clears d_val.
`timescale 1ns/1ps
`default_nettype none
`include "tcu_defs.svh"

module tcu_int_fedp #(
    parameter int N = `TCU_NUM_LANES
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  tcu_pkg::fmt_t      fmt_s,
    input  logic [N-1:0][31:0] a_row,
    input  logic [N-1:0][31:0] b_col,
    input  logic [31:0]        c_val,
    input  logic [7:0]         sf_a,
    input  logic [7:0]         sf_b,
    output logic [31:0]        d_val
);

    tcu_dp_if #(.N(N)) dp ();

    // lane products and scale bundle run in parallel
    tcu_int_mul #(
        .N (N)
    ) u_mul (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .fmt_s  (fmt_s),
        .a_row  (a_row),
        .b_col  (b_col),
        .dp     (dp)
    );

    tcu_scale_unit u_scale (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .fmt_s  (fmt_s),
        .c_val  (c_val),
        .sf_a   (sf_a),
        .sf_b   (sf_b),
        .dp     (dp)
    );

    tcu_int_acc #(
        .N (N)
    ) u_acc (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .dp     (dp),
        .d_val  (d_val)
    );

endmodule

`default_nettype wire

//--- tcu_int_fedp_chk.sv
// Concurrent checks on the dot-product top level, bound to every instance.
// fail_count is read by the testbench at the end of the run.
`timescale 1ns/1ps
`default_nettype none

module tcu_int_fedp_chk (
    input logic          clk,
    input logic          reset,
    input logic          enable,
    input tcu_pkg::fmt_t fmt_s,
    input logic [31:0]   d_val
);

    int fail_count = 0;

    // reset clears every stage
    a_zero_after_reset: assert property (@(posedge clk) reset |=> (d_val == 32'd0))
        else begin
            fail_count++;
            $error("d_val not zero after reset");
        end

    // a stalled edge leaves the output alone
    a_hold_when_stalled: assert property (@(posedge clk) (!enable && !reset) |=> $stable(d_val))
        else begin
            fail_count++;
            $error("d_val changed on an edge with enable low");
        end

    a_fmt_known: assert property (@(posedge clk) enable |-> !$isunknown(fmt_s))
        else begin
            fail_count++;
            $error("fmt_s unknown while enable is high");
        end

endmodule

bind tcu_int_fedp tcu_int_fedp_chk u_chk (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .fmt_s  (fmt_s),
    .d_val  (d_val)
);

`default_nettype wire

//--- tcu_int_fedp_tb.sv
// Self-checking testbench for the integer dot-product unit.
// Stimulus comes from a fixed-seed Galois LFSR; a queue model predicts d_val.
// Assertion failures in the bound checker are added to the final verdict.
`timescale 1ns/1ps
`default_nettype none
`include "tcu_defs.svh"

module tcu_int_fedp_tb;
    import tcu_pkg::*;

    localparam int N            = `TCU_NUM_LANES;
    localparam int LAT          = `TCU_TOTAL_LATENCY;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] SEED = 32'h14c0_4de8;

    localparam int T1_CYCLES = 300;
    localparam int T2_CYCLES = 300;
    localparam int T3_CYCLES = 300;
    localparam int T4_CYCLES = 200;
    localparam int T5_CYCLES = 300;
    localparam int T6_CYCLES = 100;
    localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                + T4_CYCLES + T5_CYCLES + T6_CYCLES + 6 * LAT;
    localparam int TIMEOUT_NS = TOTAL_CYCLES * 2 * CLK_PERIOD;

    localparam int MODE_I8     = 0;
    localparam int MODE_NARROW = 1;
    localparam int MODE_MX     = 2;
    localparam int MODE_MIX    = 3;
    localparam int MODE_STALL  = 4;
    localparam int MODE_RESET  = 5;

    logic               clk;
    logic               reset;
    logic               enable;
    fmt_t               fmt_s;
    logic [N-1:0][31:0] a_row;
    logic [N-1:0][31:0] b_col;
    logic [31:0]        c_val;
    logic [7:0]         sf_a;
    logic [7:0]         sf_b;
    logic [31:0]        d_val;

    logic [31:0] lfsr_state = SEED;
    logic [31:0] exp_q[$];
    int          tag_q[$];
    int          edge_idx   = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          stall_left = 0;
    bit          tracking   = 1'b0;
    bit          zero_watch = 1'b0;

    tcu_int_fedp #(.N(N)) DUT (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .fmt_s  (fmt_s),
        .a_row  (a_row),
        .b_col  (b_col),
        .c_val  (c_val),
        .sf_a   (sf_a),
        .sf_b   (sf_b),
        .d_val  (d_val)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one LFSR step per bit, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic fmt_t pick_fmt();
        case (rand_bits(3) % 5)
            0: return FMT_I8;
            1: return FMT_U8;
            2: return FMT_I4;
            3: return FMT_U4;
            default: return FMT_MXI8;
        endcase
    endfunction

    // element j of a word as a plain integer
    function automatic int elem(input logic [31:0] w, input int j, input int width, input bit sgn);
        int v;
        v = int'((w >> (j * width)) & ((32'd1 << width) - 32'd1));
        if (sgn && v >= (1 << (width - 1))) begin
            v = v - (1 << width);
        end
        return v;
    endfunction

    function automatic logic [31:0] lane_model(input fmt_t f, input logic [31:0] a,
                                               input logic [31:0] b);
        int          width;
        bit          sgn;
        logic [31:0] sum;
        sum = '0;
        case (f)
            FMT_I8, FMT_MXI8: begin
                width = 8;
                sgn = 1'b1;
            end
            FMT_U8: begin
                width = 8;
                sgn = 1'b0;
            end
            FMT_I4: begin
                width = 4;
                sgn = 1'b1;
            end
            FMT_U4: begin
                width = 4;
                sgn = 1'b0;
            end
            default: return '0;
        endcase
        for (int j = 0; j < 32 / width; j++) begin
            sum = sum + 32'(elem(a, j, width, sgn) * elem(b, j, width, sgn));
        end
        return sum;
    endfunction

    function automatic logic [31:0] expected_result(
        input fmt_t f, input logic [N-1:0][31:0] a, input logic [N-1:0][31:0] b,
        input logic [31:0] c, input logic [7:0] sfa, input logic [7:0] sfb);
        logic [31:0] total;
        logic [31:0] scaled;
        int          shift;
        longint      t;
        longint      mag;
        total = '0;
        for (int i = 0; i < N; i++) begin
            total = total + lane_model(f, a[i], b[i]);
        end
        shift = 0;
        if (f == FMT_MXI8) begin
            shift = (int'(sfa) - int'(E8M0_BIAS)) + (int'(sfb) - int'(E8M0_BIAS));
        end
        t = longint'($signed(total));
        if (shift >= 32 || shift <= -32) begin
            scaled = '0;
        end else if (shift >= 0) begin
            scaled = total << shift;
        end else begin
            // truncate the magnitude, then put the sign back
            mag = (t < 0) ? -t : t;
            mag = mag >> (-shift);
            scaled = 32'((t < 0) ? -mag : mag);
        end
        return scaled + c;
    endfunction

    task automatic drive(input int mode);
        case (mode)
            MODE_MIX, MODE_RESET: enable = 1'b1;
            MODE_STALL: begin
                if (stall_left > 0) begin
                    enable = 1'b0;
                    stall_left--;
                end else if (rand_bits(3) == 0) begin
                    enable = 1'b0;
                    stall_left = int'(rand_bits(3));
                end else begin
                    enable = 1'b1;
                end
            end
            default: enable = (rand_bits(2) != 0);
        endcase
        case (mode)
            MODE_I8: fmt_s = FMT_I8;
            MODE_NARROW: fmt_s = (rand_bits(1) != 0) ? FMT_U8
                                 : ((rand_bits(1) != 0) ? FMT_I4 : FMT_U4);
            MODE_MX: fmt_s = FMT_MXI8;
            default: fmt_s = pick_fmt();
        endcase
        for (int i = 0; i < N; i++) begin
            a_row[i] = rand_bits(32);
            b_col[i] = rand_bits(32);
        end
        c_val = rand_bits(32);
        // addend close to the top so the sum wraps
        if (mode == MODE_NARROW && rand_bits(1) != 0) begin
            c_val[31:12] = '1;
        end
        if (mode == MODE_MX && rand_bits(3) == 0) begin
            sf_a = (rand_bits(1) != 0) ? 8'hff : 8'h00;
            sf_b = (rand_bits(1) != 0) ? 8'hff : 8'h00;
        end else if (mode == MODE_MX) begin
            sf_a = 8'd120 + 8'(rand_bits(5));
            sf_b = 8'd120 + 8'(rand_bits(5));
        end else begin
            sf_a = 8'(rand_bits(8));
            sf_b = 8'(rand_bits(8));
        end
    endtask

    // called 1 ns after a rising edge, with the inputs that edge sampled
    task automatic observe();
        logic [31:0] expv;
        if (!reset && enable) begin
            edge_idx++;
            if (zero_watch && edge_idx < LAT) begin
                checks++;
                assert (d_val === 32'd0) else begin
                    errors++;
                    $display("Error at %0t: d_val %h before the first result, expected 0",
                             $time, d_val);
                end
            end
            if (tracking) begin
                exp_q.push_back(expected_result(fmt_s, a_row, b_col, c_val, sf_a, sf_b));
                tag_q.push_back(edge_idx);
            end
            // the sampling edge counts as the first of the LAT edges
            if (tag_q.size() > 0 && edge_idx - tag_q[0] == LAT - 1) begin
                expv = exp_q.pop_front();
                void'(tag_q.pop_front());
                checks++;
                assert (d_val === expv) else begin
                    errors++;
                    $display("Error at %0t: d_val %h, expected %h", $time, d_val, expv);
                end
            end
        end
    endtask

    task automatic run_cycles(input int n, input int mode);
        for (int i = 0; i < n; i++) begin
            drive(mode);
            @(posedge clk);
            #1;
            observe();
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        enable = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        edge_idx = 0;
        exp_q.delete();
        tag_q.delete();
    endtask

    task automatic finish_test(input int id, input string name, input int chk0, input int err0);
        tracking = 1'b0;
        // push the last tracked results out with untracked inputs
        for (int i = 0; i < LAT - 1; i++) begin
            drive(MODE_MIX);
            @(posedge clk);
            #1;
            observe();
        end
        enable = 1'b0;
        $display("test %0d %s: %s, %0d checks, %0d mismatches", id, name,
                 (errors == err0) ? "pass" : "fail", checks - chk0, errors - err0);
    endtask

    task automatic run_test(input int id, input string name, input int mode, input int cycles);
        int chk0;
        int err0;
        chk0 = checks;
        err0 = errors;
        tracking = 1'b1;
        run_cycles(cycles, mode);
        finish_test(id, name, chk0, err0);
    endtask

    task automatic reset_test(input int cycles);
        int chk0;
        int err0;
        chk0 = checks;
        err0 = errors;
        apply_reset();
        checks++;
        assert (d_val === 32'd0) else begin
            errors++;
            $display("Error at %0t: d_val %h right after reset, expected 0", $time, d_val);
        end
        zero_watch = 1'b1;
        tracking = 1'b1;
        // addend alone, odd, so the first arrival is visible
        drive(MODE_RESET);
        a_row = '0;
        c_val[0] = 1'b1;
        @(posedge clk);
        #1;
        observe();
        run_cycles(cycles - 1, MODE_RESET);
        finish_test(6, "reset and first-result latency", chk0, err0);
        zero_watch = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        fmt_s = FMT_I8;
        a_row = '0;
        b_col = '0;
        c_val = '0;
        sf_a = '0;
        sf_b = '0;
        apply_reset();
        run_test(1, "signed int8", MODE_I8, T1_CYCLES);
        run_test(2, "unsigned int8 and int4", MODE_NARROW, T2_CYCLES);
        run_test(3, "scaled int8", MODE_MX, T3_CYCLES);
        run_test(4, "back-to-back mixed formats", MODE_MIX, T4_CYCLES);
        run_test(5, "enable stalls", MODE_STALL, T5_CYCLES);
        reset_test(T6_CYCLES);
        errors = errors + DUT.u_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_chk.fail_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
tcu_pkg.sv
tcu_dp_if.sv
tcu_pipe_reg.sv
tcu_int_mul.sv
tcu_scale_unit.sv
tcu_int_acc.sv
tcu_int_fedp.sv
tcu_int_fedp_chk.sv
tcu_int_fedp_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tcu_int_fedp_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG    = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
